// ==== include/spi_mem_macros.svh ====
// SPI memory shared sizes
// Address, data, synchronizer depth and host bus width
`ifndef SPI_MEM_MACROS_SVH
`define SPI_MEM_MACROS_SVH

// Memory geometry, 128 x 8
`define SPI_MEM_ADDR_W 7
`define SPI_MEM_DATA_W 8

// Flops in each pin synchronizer
`define SPI_MEM_SYNC_STAGES 2

// AXI4-Lite data bus, only byte lane 0 is used
`define SPI_MEM_AXI_DATA_W 32

`endif

// ==== logic/spi_mem_pkg.sv ====
// SPI memory types
// Frontend states, memory opcodes and requester indices
package spi_mem_pkg;

    // SPI frontend FSM
    typedef enum logic [2:0] {
        SPI_IDLE,       // Chip select high
        SPI_CMD,        // Shifting in address and R/W flag
        SPI_RD_WAIT,    // Read request outstanding
        SPI_RD_SHIFT,   // Shifting read byte out on miso
        SPI_WR_DATA,    // Shifting in write byte
        SPI_WR_WAIT,    // Write request outstanding
        SPI_DONE        // Byte finished, wait for cs_n
    } spi_state_t;

    // Memory opcode
    typedef enum logic {
        MEM_READ,
        MEM_WRITE
    } mem_op_t;

    // Requester index for round robin and read routing
    typedef enum logic {
        SRC_SPI,
        SRC_AXI
    } mem_src_t;

endpackage

// ==== logic/input_conditioner.sv ====
// Input conditioner
// Brings one asynchronous pin into clk and flags its edges
`timescale 1ns/100ps
`include "spi_mem_macros.svh"

module input_conditioner #(
    parameter logic RESET_VAL = 1'b0    // Idle level of the pin
) (
    input  logic clk,
    input  logic rst,
    input  logic pin,
    output logic level,
    output logic rise,
    output logic fall
);

    logic [`SPI_MEM_SYNC_STAGES-1:0] sync_q;    // Synchronizer chain
    logic                            history_q; // Level one cycle ago

    always_ff @(posedge clk) begin
        if (rst) begin
            sync_q    <= {`SPI_MEM_SYNC_STAGES{RESET_VAL}};
            history_q <= RESET_VAL;
        end else begin
            sync_q    <= {sync_q[`SPI_MEM_SYNC_STAGES-2:0], pin};
            history_q <= sync_q[`SPI_MEM_SYNC_STAGES-1];
        end
    end

    assign level = sync_q[`SPI_MEM_SYNC_STAGES-1];
    assign rise  = level & ~history_q;  // Low to high
    assign fall  = ~level & history_q;  // High to low

    // Every edge pulse traces back to a pin change through the whole chain
    a_edge_latency: assert property (@(posedge clk) disable iff (rst)
        (rise || fall) |->
            $past(pin, `SPI_MEM_SYNC_STAGES) != $past(pin, `SPI_MEM_SYNC_STAGES + 1));

endmodule

// ==== logic/spi_frontend.sv ====
// SPI slave frontend, mode 0
// Command byte carries address and R/W flag, then one data byte
`timescale 1ns/100ps
`include "spi_mem_macros.svh"

module spi_frontend (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       sclk_rise,
    input  logic                       sclk_fall,
    input  logic                       cs_level,
    input  logic                       mosi_level,
    input  logic                       gnt,
    input  logic                       rvalid,
    input  logic [`SPI_MEM_DATA_W-1:0] rdata,
    output logic                       req,
    output spi_mem_pkg::mem_op_t       op,
    output logic [`SPI_MEM_ADDR_W-1:0] addr,
    output logic [`SPI_MEM_DATA_W-1:0] wdata,
    output logic                       miso,
    output logic                       miso_en
);

    spi_mem_pkg::spi_state_t     state_q;
    logic [2:0]                  bit_cnt_q;  // Rises seen in current byte
    logic [`SPI_MEM_DATA_W-1:0]  shift_q;    // Shared in/out shift register

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= spi_mem_pkg::SPI_IDLE;
            bit_cnt_q <= 3'd0;
            req       <= 1'b0;
            miso      <= 1'b0;
            miso_en   <= 1'b0;
        end else begin
            // Request runs to its grant even if cs_n aborts meanwhile
            if (gnt) begin
                req <= 1'b0;
            end

            if (cs_level) begin
                state_q <= spi_mem_pkg::SPI_IDLE;   // Abort, drop partial byte
                miso    <= 1'b0;
                miso_en <= 1'b0;
            end else begin
                case (state_q)
                    spi_mem_pkg::SPI_IDLE: begin
                        bit_cnt_q <= 3'd0;
                        state_q   <= spi_mem_pkg::SPI_CMD;
                    end

                    //--------------------------------------------------
                    // Command byte, MSB first
                    //--------------------------------------------------
                    spi_mem_pkg::SPI_CMD: begin
                        if (sclk_rise) begin
                            shift_q   <= {shift_q[6:0], mosi_level};
                            bit_cnt_q <= bit_cnt_q + 3'd1;  // Wraps to 0 after 8th
                            if (bit_cnt_q == 3'd7) begin
                                addr <= shift_q[6:0];       // Upper seven bits
                                if (mosi_level) begin       // Read flag
                                    op      <= spi_mem_pkg::MEM_READ;
                                    req     <= 1'b1;
                                    miso_en <= 1'b1;
                                    state_q <= spi_mem_pkg::SPI_RD_WAIT;
                                end else begin
                                    state_q <= spi_mem_pkg::SPI_WR_DATA;
                                end
                            end
                        end
                    end

                    //--------------------------------------------------
                    // Read path
                    //--------------------------------------------------
                    spi_mem_pkg::SPI_RD_WAIT: begin
                        if (rvalid) begin
                            shift_q <= rdata;               // Bit 7 goes out next fall
                            state_q <= spi_mem_pkg::SPI_RD_SHIFT;
                        end
                    end

                    spi_mem_pkg::SPI_RD_SHIFT: begin
                        if (sclk_fall) begin
                            miso    <= shift_q[7];
                            shift_q <= {shift_q[6:0], 1'b0};
                        end
                        if (sclk_rise) begin
                            bit_cnt_q <= bit_cnt_q + 3'd1;
                            if (bit_cnt_q == 3'd7) begin
                                state_q <= spi_mem_pkg::SPI_DONE;
                            end
                        end
                    end

                    //--------------------------------------------------
                    // Write path
                    //--------------------------------------------------
                    spi_mem_pkg::SPI_WR_DATA: begin
                        if (sclk_rise) begin
                            shift_q   <= {shift_q[6:0], mosi_level};
                            bit_cnt_q <= bit_cnt_q + 3'd1;
                            if (bit_cnt_q == 3'd7) begin
                                wdata   <= {shift_q[6:0], mosi_level};
                                op      <= spi_mem_pkg::MEM_WRITE;
                                req     <= 1'b1;
                                state_q <= spi_mem_pkg::SPI_WR_WAIT;
                            end
                        end
                    end

                    spi_mem_pkg::SPI_WR_WAIT: begin
                        if (gnt) begin
                            state_q <= spi_mem_pkg::SPI_DONE;
                        end
                    end

                    spi_mem_pkg::SPI_DONE: state_q <= spi_mem_pkg::SPI_DONE;  // Until cs_n rises

                    default: state_q <= spi_mem_pkg::SPI_IDLE;
                endcase
            end
        end
    end

    a_no_req_idle: assert property (@(posedge clk) disable iff (rst)
        $rose(req) |-> state_q != spi_mem_pkg::SPI_IDLE);

endmodule

// ==== logic/axil_mem_port.sv ====
// AXI4-Lite slave port onto the shared memory
// One transaction at a time, byte lane 0 only, always OKAY
`timescale 1ns/100ps
`include "spi_mem_macros.svh"

module axil_mem_port (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           s_awvalid,
    input  logic [`SPI_MEM_ADDR_W-1:0]     s_awaddr,
    output logic                           s_awready,
    input  logic                           s_wvalid,
    input  logic [`SPI_MEM_AXI_DATA_W-1:0] s_wdata,
    input  logic [3:0]                     s_wstrb,
    output logic                           s_wready,
    output logic                           s_bvalid,
    output logic [1:0]                     s_bresp,
    input  logic                           s_bready,
    input  logic                           s_arvalid,
    input  logic [`SPI_MEM_ADDR_W-1:0]     s_araddr,
    output logic                           s_arready,
    output logic                           s_rvalid,
    output logic [`SPI_MEM_AXI_DATA_W-1:0] s_rdata,
    output logic [1:0]                     s_rresp,
    input  logic                           s_rready,
    input  logic                           gnt,
    input  logic                           rvalid,
    input  logic [`SPI_MEM_DATA_W-1:0]     rdata,
    output logic                           req,
    output spi_mem_pkg::mem_op_t           op,
    output logic [`SPI_MEM_ADDR_W-1:0]     addr,
    output logic [`SPI_MEM_DATA_W-1:0]     wdata
);

    typedef enum logic [2:0] {
        AX_IDLE,
        AX_WR_REQ,      // Write waiting for grant
        AX_B,           // Holding bvalid
        AX_RD_REQ,      // Read waiting for grant
        AX_RD_DATA,     // Waiting for memory data
        AX_R            // Holding rvalid
    } ax_state_t;

    ax_state_t state_q;

    assign s_bresp = 2'b00;     // OKAY
    assign s_rresp = 2'b00;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= AX_IDLE;
            req       <= 1'b0;
            s_awready <= 1'b0;
            s_wready  <= 1'b0;
            s_arready <= 1'b0;
            s_bvalid  <= 1'b0;
            s_rvalid  <= 1'b0;
        end else begin
            s_awready <= 1'b0;  // Ready strobes last one cycle
            s_wready  <= 1'b0;
            s_arready <= 1'b0;
            case (state_q)
                AX_IDLE: begin
                    if (s_awvalid && s_wvalid) begin    // Writes win over reads
                        s_awready <= 1'b1;
                        s_wready  <= 1'b1;
                        addr      <= s_awaddr;
                        wdata     <= s_wdata[`SPI_MEM_DATA_W-1:0];
                        op        <= spi_mem_pkg::MEM_WRITE;
                        if (s_wstrb[0]) begin
                            req     <= 1'b1;
                            state_q <= AX_WR_REQ;
                        end else begin
                            s_bvalid <= 1'b1;   // Lane masked, nothing to write
                            state_q  <= AX_B;
                        end
                    end else if (s_arvalid) begin
                        s_arready <= 1'b1;
                        addr      <= s_araddr;
                        op        <= spi_mem_pkg::MEM_READ;
                        req       <= 1'b1;
                        state_q   <= AX_RD_REQ;
                    end
                end
                AX_WR_REQ: if (gnt) begin
                    req      <= 1'b0;
                    s_bvalid <= 1'b1;
                    state_q  <= AX_B;
                end
                AX_B: if (s_bready) begin
                    s_bvalid <= 1'b0;
                    state_q  <= AX_IDLE;
                end
                AX_RD_REQ: if (gnt) begin
                    req     <= 1'b0;
                    state_q <= AX_RD_DATA;
                end
                AX_RD_DATA: if (rvalid) begin
                    s_rdata  <= {{(`SPI_MEM_AXI_DATA_W-`SPI_MEM_DATA_W){1'b0}}, rdata};
                    s_rvalid <= 1'b1;
                    state_q  <= AX_R;
                end
                AX_R: if (s_rready) begin
                    s_rvalid <= 1'b0;
                    state_q  <= AX_IDLE;
                end
                default: state_q <= AX_IDLE;
            endcase
        end
    end

    a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        s_bvalid && !s_bready |=> s_bvalid);

endmodule

// ==== logic/mem_arbiter.sv ====
// Round-robin arbiter between SPI and AXI requesters
// Drives the memory port and routes read valid back to its owner
`timescale 1ns/100ps
`include "spi_mem_macros.svh"

module mem_arbiter (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       spi_req,
    input  spi_mem_pkg::mem_op_t       spi_op,
    input  logic [`SPI_MEM_ADDR_W-1:0] spi_addr,
    input  logic [`SPI_MEM_DATA_W-1:0] spi_wdata,
    input  logic                       axi_req,
    input  spi_mem_pkg::mem_op_t       axi_op,
    input  logic [`SPI_MEM_ADDR_W-1:0] axi_addr,
    input  logic [`SPI_MEM_DATA_W-1:0] axi_wdata,
    output logic                       spi_gnt,
    output logic                       axi_gnt,
    output logic                       spi_rvalid,
    output logic                       axi_rvalid,
    output logic                       mem_en,
    output logic                       mem_we,
    output logic [`SPI_MEM_ADDR_W-1:0] mem_addr,
    output logic [`SPI_MEM_DATA_W-1:0] mem_wdata
);

    spi_mem_pkg::mem_src_t last_q;      // Winner of the previous grant
    spi_mem_pkg::mem_src_t rd_owner_q;  // Who gets this cycle's read data
    logic                  rd_pend_q;   // Read issued last cycle

    // Lone request wins at once, a tie goes to last cycle's loser
    assign spi_gnt = spi_req && (!axi_req || last_q == spi_mem_pkg::SRC_AXI);
    assign axi_gnt = axi_req && (!spi_req || last_q == spi_mem_pkg::SRC_SPI);

    assign mem_en    = spi_gnt | axi_gnt;
    assign mem_we    = axi_gnt ? (axi_op == spi_mem_pkg::MEM_WRITE)
                               : (spi_gnt && spi_op == spi_mem_pkg::MEM_WRITE);
    assign mem_addr  = axi_gnt ? axi_addr : spi_addr;
    assign mem_wdata = axi_gnt ? axi_wdata : spi_wdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            last_q    <= spi_mem_pkg::SRC_SPI;
            rd_pend_q <= 1'b0;
        end else begin
            rd_pend_q <= mem_en && !mem_we;
            if (mem_en) begin
                last_q <= axi_gnt ? spi_mem_pkg::SRC_AXI : spi_mem_pkg::SRC_SPI;
            end
        end
    end

    always_ff @(posedge clk) begin
        rd_owner_q <= axi_gnt ? spi_mem_pkg::SRC_AXI : spi_mem_pkg::SRC_SPI;
    end

    assign spi_rvalid = rd_pend_q && rd_owner_q == spi_mem_pkg::SRC_SPI;
    assign axi_rvalid = rd_pend_q && rd_owner_q == spi_mem_pkg::SRC_AXI;

    // A request that lost a tie is served on the next cycle
    a_spi_served: assert property (@(posedge clk) disable iff (rst)
        spi_req && !spi_gnt |=> spi_gnt);
    a_axi_served: assert property (@(posedge clk) disable iff (rst)
        axi_req && !axi_gnt |=> axi_gnt);

endmodule

// ==== logic/data_memory.sv ====
// Shared data memory, 128 x 8
// Synchronous write, registered read
`timescale 1ns/100ps
`include "spi_mem_macros.svh"

module data_memory (
    input  logic                       clk,
    input  logic                       en,
    input  logic                       we,
    input  logic [`SPI_MEM_ADDR_W-1:0] addr,
    input  logic [`SPI_MEM_DATA_W-1:0] wdata,
    output logic [`SPI_MEM_DATA_W-1:0] rdata
);

    logic [`SPI_MEM_DATA_W-1:0] mem_q [0:(1 << `SPI_MEM_ADDR_W)-1];

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem_q[addr] <= wdata;   // rdata keeps its last read
            end else begin
                rdata <= mem_q[addr];   // Valid one cycle after en
            end
        end
    end

endmodule

// ==== logic/spi_memory.sv ====
// SPI memory top level
// SPI slave and AXI4-Lite slave sharing one data memory
`timescale 1ns/100ps
`include "spi_mem_macros.svh"

module spi_memory (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           sclk,
    input  logic                           cs_n,
    input  logic                           mosi,
    output logic                           miso,
    output logic                           miso_en,
    input  logic                           s_awvalid,
    input  logic [`SPI_MEM_ADDR_W-1:0]     s_awaddr,
    output logic                           s_awready,
    input  logic                           s_wvalid,
    input  logic [`SPI_MEM_AXI_DATA_W-1:0] s_wdata,
    input  logic [3:0]                     s_wstrb,
    output logic                           s_wready,
    output logic                           s_bvalid,
    output logic [1:0]                     s_bresp,
    input  logic                           s_bready,
    input  logic                           s_arvalid,
    input  logic [`SPI_MEM_ADDR_W-1:0]     s_araddr,
    output logic                           s_arready,
    output logic                           s_rvalid,
    output logic [`SPI_MEM_AXI_DATA_W-1:0] s_rdata,
    output logic [1:0]                     s_rresp,
    input  logic                           s_rready
);

    //--------------------------------------------------
    // Pin conditioning
    //--------------------------------------------------
    logic sclk_rise, sclk_fall, cs_level, mosi_level;

    input_conditioner sclk_cond_i (.clk(clk), .rst(rst), .pin(sclk),
        .level(), .rise(sclk_rise), .fall(sclk_fall));
    input_conditioner #(.RESET_VAL(1'b1)) cs_cond_i (.clk(clk), .rst(rst), .pin(cs_n),
        .level(cs_level), .rise(), .fall());    // Deselected while in reset
    input_conditioner mosi_cond_i (.clk(clk), .rst(rst), .pin(mosi),
        .level(mosi_level), .rise(), .fall());

    //--------------------------------------------------
    // Requesters
    //--------------------------------------------------
    logic                       spi_req, spi_gnt, spi_rvalid;
    spi_mem_pkg::mem_op_t       spi_op;
    logic [`SPI_MEM_ADDR_W-1:0] spi_addr;
    logic [`SPI_MEM_DATA_W-1:0] spi_wdata;
    logic                       axi_req, axi_gnt, axi_rvalid;
    spi_mem_pkg::mem_op_t       axi_op;
    logic [`SPI_MEM_ADDR_W-1:0] axi_addr;
    logic [`SPI_MEM_DATA_W-1:0] axi_wdata;
    logic [`SPI_MEM_DATA_W-1:0] mem_rdata;  // Shared by both requesters

    spi_frontend spi_frontend_i (.clk(clk), .rst(rst), .sclk_rise(sclk_rise),
        .sclk_fall(sclk_fall), .cs_level(cs_level), .mosi_level(mosi_level),
        .gnt(spi_gnt), .rvalid(spi_rvalid), .rdata(mem_rdata), .req(spi_req),
        .op(spi_op), .addr(spi_addr), .wdata(spi_wdata), .miso(miso), .miso_en(miso_en));

    axil_mem_port axil_mem_port_i (.clk(clk), .rst(rst),
        .s_awvalid(s_awvalid), .s_awaddr(s_awaddr), .s_awready(s_awready),
        .s_wvalid(s_wvalid), .s_wdata(s_wdata), .s_wstrb(s_wstrb), .s_wready(s_wready),
        .s_bvalid(s_bvalid), .s_bresp(s_bresp), .s_bready(s_bready),
        .s_arvalid(s_arvalid), .s_araddr(s_araddr), .s_arready(s_arready),
        .s_rvalid(s_rvalid), .s_rdata(s_rdata), .s_rresp(s_rresp), .s_rready(s_rready),
        .gnt(axi_gnt), .rvalid(axi_rvalid), .rdata(mem_rdata), .req(axi_req),
        .op(axi_op), .addr(axi_addr), .wdata(axi_wdata));

    //--------------------------------------------------
    // Arbitration and storage
    //--------------------------------------------------
    logic                       mem_en, mem_we;
    logic [`SPI_MEM_ADDR_W-1:0] mem_addr;
    logic [`SPI_MEM_DATA_W-1:0] mem_wdata;

    mem_arbiter mem_arbiter_i (.clk(clk), .rst(rst),
        .spi_req(spi_req), .spi_op(spi_op), .spi_addr(spi_addr), .spi_wdata(spi_wdata),
        .axi_req(axi_req), .axi_op(axi_op), .axi_addr(axi_addr), .axi_wdata(axi_wdata),
        .spi_gnt(spi_gnt), .axi_gnt(axi_gnt), .spi_rvalid(spi_rvalid),
        .axi_rvalid(axi_rvalid), .mem_en(mem_en), .mem_we(mem_we),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata));

    data_memory data_memory_i (.clk(clk), .en(mem_en), .we(mem_we),
        .addr(mem_addr), .wdata(mem_wdata), .rdata(mem_rdata));

endmodule

// ==== sim/tb_spi_memory.sv ====
// Testbench for the dual port SPI / AXI4-Lite memory
// Table of SPI and AXI operations checked against a reference array
`timescale 1ns/100ps
`include "spi_mem_macros.svh"

module tb_spi_memory;

    localparam int SPI_HALF = 10;   // sclk half period in clk cycles

    typedef enum logic [2:0] {
        K_SPI_WR, K_SPI_RD, K_AXI_WR, K_AXI_RD, K_SPI_ABORT, K_PAIR
    } kind_t;

    typedef struct packed {
        kind_t      kind;
        logic [6:0] addr;
        logic [7:0] data;
        logic [3:0] strb;
    } row_t;

    logic        clk, rst, sclk, cs_n, mosi, miso, miso_en;
    logic        s_awvalid, s_awready, s_wvalid, s_wready, s_bvalid, s_bready;
    logic        s_arvalid, s_arready, s_rvalid, s_rready;
    logic [6:0]  s_awaddr, s_araddr;
    logic [31:0] s_wdata, s_rdata;
    logic [3:0]  s_wstrb;
    logic [1:0]  s_bresp, s_rresp;

    row_t       rows[$];
    logic [7:0] ref_mem [0:127];   // Expected memory contents
    int         seed = 82;
    int         cycle_cnt = 0;
    int         cycle_limit = 1000; // Raised once the table is built

    spi_memory spi_memory_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Watchdog
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("SIMULATION FAILED");
            $fatal(1, "Timeout, run did not finish within %0d cycles", cycle_limit);
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0d ns %s: got 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "Value mismatch on %s", name);
        end
    endtask

    function automatic logic [7:0] rand_byte();
        int r;
        r = $random(seed);
        return r[7:0];
    endfunction

    task automatic add_row(input kind_t k, input logic [6:0] a, input logic [3:0] s);
        row_t r;
        r.kind = k;
        r.addr = a;
        r.data = rand_byte();
        r.strb = s;
        rows.push_back(r);
    endtask

    //--------------------------------------------------
    // Bus drivers, all inputs change on falling clk
    //--------------------------------------------------
    task automatic spi_transfer(input logic [7:0] cmd, input logic [7:0] tx,
                                input int nbits, output logic [7:0] rx);
        logic [15:0] frame;
        int          i;
        frame = {cmd, tx};
        rx    = 8'h00;
        @(negedge clk);
        cs_n = 1'b0;
        for (i = 0; i < nbits; i++) begin
            mosi = frame[15-i];                 // Set up while sclk low
            repeat (SPI_HALF) @(negedge clk);
            if (i >= 8 && cmd[0]) begin         // Data byte of a read
                check_value("miso_en", {31'd0, miso_en}, 32'd1);
                rx = {rx[6:0], miso};           // Sample just before rise
            end
            sclk = 1'b1;
            repeat (SPI_HALF) @(negedge clk);
            sclk = 1'b0;
        end
        repeat (SPI_HALF) @(negedge clk);
        cs_n = 1'b1;
        mosi = 1'b0;
        repeat (SPI_HALF) @(negedge clk);       // cs_n high gap
    endtask

    task automatic axi_write(input logic [6:0] a, input logic [7:0] d,
                             input logic [3:0] strb, output logic [1:0] resp);
        @(negedge clk);
        s_awvalid = 1'b1;
        s_awaddr  = a;
        s_wvalid  = 1'b1;
        s_wdata   = {24'h5a5a5a, d};    // Upper lanes are ignored
        s_wstrb   = strb;
        do @(negedge clk); while (!s_awready);
        check_value("s_wready", {31'd0, s_wready}, 32'd1);  // Raised with awready
        @(negedge clk);                 // Handshake edge passed
        s_awvalid = 1'b0;
        s_wvalid  = 1'b0;
        while (!s_bvalid) @(negedge clk);
        resp     = s_bresp;
        s_bready = 1'b1;
        @(negedge clk);
        s_bready = 1'b0;
    endtask

    task automatic axi_read(input logic [6:0] a, output logic [31:0] d,
                            output logic [1:0] resp);
        @(negedge clk);
        s_arvalid = 1'b1;
        s_araddr  = a;
        do @(negedge clk); while (!s_arready);
        @(negedge clk);
        s_arvalid = 1'b0;
        while (!s_rvalid) @(negedge clk);
        d        = s_rdata;
        resp     = s_rresp;
        s_rready = 1'b1;
        @(negedge clk);
        s_rready = 1'b0;
    endtask

    //--------------------------------------------------
    // One table row
    //--------------------------------------------------
    task automatic run_row(input row_t r);
        logic [7:0]  rx;
        logic [7:0]  wr_byte;
        logic [31:0] rd;
        logic [1:0]  resp;
        case (r.kind)
            K_SPI_WR: begin
                spi_transfer({r.addr, 1'b0}, r.data, 16, rx);
                ref_mem[r.addr] = r.data;
            end
            K_SPI_RD: begin
                spi_transfer({r.addr, 1'b1}, 8'h00, 16, rx);
                check_value("miso byte", {24'd0, rx}, {24'd0, ref_mem[r.addr]});
                check_value("miso_en", {31'd0, miso_en}, 32'd0);
            end
            K_AXI_WR: begin
                // Masked lane carries the inverse of the stored byte
                wr_byte = r.strb[0] ? r.data : ~ref_mem[r.addr];
                axi_write(r.addr, wr_byte, r.strb, resp);
                check_value("s_bresp", {30'd0, resp}, 32'd0);
                if (r.strb[0]) ref_mem[r.addr] = wr_byte;  // Lane 0 gates the write
            end
            K_AXI_RD: begin
                axi_read(r.addr, rd, resp);
                check_value("s_rdata", rd, {24'd0, ref_mem[r.addr]});
                check_value("s_rresp", {30'd0, resp}, 32'd0);
            end
            K_SPI_ABORT: begin
                // Cut in data byte, which differs from the stored byte
                spi_transfer({r.addr, 1'b0}, ~ref_mem[r.addr], 12, rx);
                check_value("miso_en", {31'd0, miso_en}, 32'd0);
            end
            default: begin  // SPI and AXI writes started together
                fork
                    spi_transfer({r.addr, 1'b0}, r.data, 16, rx);
                    axi_write(r.addr ^ 7'h40, ~r.data, 4'h1, resp);
                join
                check_value("s_bresp", {30'd0, resp}, 32'd0);
                ref_mem[r.addr]         = r.data;
                ref_mem[r.addr ^ 7'h40] = ~r.data;
            end
        endcase
    endtask

    initial begin
        int i;
        rst = 1'b1;
        sclk = 1'b0;
        cs_n = 1'b1;
        mosi = 1'b0;
        s_awvalid = 1'b0;
        s_awaddr  = '0;
        s_wvalid  = 1'b0;
        s_wdata   = '0;
        s_wstrb   = '0;
        s_bready  = 1'b0;
        s_arvalid = 1'b0;
        s_araddr  = '0;
        s_rready  = 1'b0;

        add_row(K_SPI_WR, 7'h05, 4'h1);     // SPI write, AXI read back
        add_row(K_AXI_RD, 7'h05, 4'h0);
        add_row(K_AXI_WR, 7'h22, 4'hf);     // AXI write, SPI read back
        add_row(K_SPI_RD, 7'h22, 4'h0);
        add_row(K_AXI_WR, 7'h30, 4'h1);
        add_row(K_AXI_WR, 7'h30, 4'he);     // Lane 0 masked
        add_row(K_AXI_RD, 7'h30, 4'h0);
        add_row(K_SPI_RD, 7'h30, 4'h0);
        add_row(K_SPI_WR, 7'h41, 4'h1);
        add_row(K_SPI_ABORT, 7'h41, 4'h1);  // Must leave 0x41 alone
        add_row(K_AXI_RD, 7'h41, 4'h0);
        add_row(K_PAIR, 7'h12, 4'h1);       // Also hits 0x52
        add_row(K_SPI_RD, 7'h12, 4'h0);
        add_row(K_AXI_RD, 7'h52, 4'h0);
        add_row(K_AXI_RD, 7'h12, 4'h0);
        cycle_limit = rows.size() * 400 + 1000;

        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value("miso_en", {31'd0, miso_en}, 32'd0);
        check_value("s_bvalid", {31'd0, s_bvalid}, 32'd0);
        check_value("s_rvalid", {31'd0, s_rvalid}, 32'd0);

        for (i = 0; i < rows.size(); i++) begin
            run_row(rows[i]);
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+include
logic/spi_mem_pkg.sv
logic/input_conditioner.sv
logic/spi_frontend.sv
logic/axil_mem_port.sv
logic/mem_arbiter.sv
logic/data_memory.sv
logic/spi_memory.sv
sim/tb_spi_memory.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the SPI memory testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_spi_memory

# The simulator exits nonzero on $fatal, so its status is kept out of set -e
out=$(./obj_dir/Vtb_spi_memory 2>&1) || true
echo "$out"

if echo "$out" | grep -q "SIMULATION PASSED"; then
    exit 0
else
    exit 1
fi
